//--- svc_cmd_pkg.sv
// Service command package
// Command byte codes of the host service interface, the decoded opcode
// enum and the rule that maps a command byte onto an opcode

package svc_cmd_pkg;

  // Command byte codes
  localparam logic [7:0] CMD_AWUSER_CORE     = 8'h01;
  localparam logic [7:0] CMD_AWUSER_MCU      = 8'h02;
  localparam logic [7:0] CMD_AWUSER_RELEASE  = 8'h03;
  localparam logic [7:0] CMD_ZEROIZE_ON      = 8'h04;
  localparam logic [7:0] CMD_ZEROIZE_OFF     = 8'h05;
  localparam logic [7:0] CMD_ZEROIZE_RELEASE = 8'h06;
  localparam logic [7:0] CMD_FORCE_TOKENS    = 8'h07;
  localparam logic [7:0] CMD_RMA_SCRAP_PPD   = 8'h08;
  localparam logic [7:0] CMD_ESCALATE        = 8'h09;
  localparam logic [7:0] CMD_CLK_500         = 8'h0A;
  localparam logic [7:0] CMD_CLK_160         = 8'h0B;
  localparam logic [7:0] CMD_CLK_400         = 8'h0C;
  localparam logic [7:0] CMD_CLK_1000        = 8'h0D;
  localparam logic [7:0] CMD_FAULT_DIGEST    = 8'h0E;
  localparam logic [7:0] CMD_FAULT_BUS_ECC   = 8'h0F;
  localparam logic [7:0] CMD_SUB_RESET       = 8'h10;

  // One opcode per command, OP_NONE for every byte that is not a command
  typedef enum logic [4:0] {
    OP_NONE,
    OP_AWUSER_CORE,
    OP_AWUSER_MCU,
    OP_AWUSER_RELEASE,
    OP_ZEROIZE_ON,
    OP_ZEROIZE_OFF,
    OP_ZEROIZE_RELEASE,
    OP_FORCE_TOKENS,
    OP_RMA_SCRAP_PPD,
    OP_ESCALATE,
    OP_CLK_500,
    OP_CLK_160,
    OP_CLK_400,
    OP_CLK_1000,
    OP_FAULT_DIGEST,
    OP_FAULT_BUS_ECC,
    OP_SUB_RESET
  } svc_op_e;

  // The codes run from 0x01 to 0x10 in the same order as the opcodes
  function automatic svc_op_e cmd_to_op(input logic [7:0] cmd);
    svc_op_e op;
    if (cmd >= CMD_AWUSER_CORE && cmd <= CMD_SUB_RESET) begin
      op = svc_op_e'(cmd[4:0]);
    end else begin
      op = OP_NONE;
    end
    return op;
  endfunction

endpackage

//--- svc_ovr_pkg.sv
// Override state package
// Modes of the forced subsystem signals, the life-cycle token constants,
// the fuse DAI fault address and the bypass clock frequency codes

package svc_ovr_pkg;

  // AXI write user field source
  typedef enum logic [1:0] {
    AWU_PASS,
    AWU_CORE,
    AWU_MCU
  } awuser_mode_e;

  // Zeroization inputs source
  typedef enum logic [1:0] {
    ZER_PASS,
    ZER_ON,
    ZER_OFF
  } zeroize_mode_e;

  // Bypass clock frequency selection
  typedef enum logic [1:0] {
    FREQ_500  = 2'd0,
    FREQ_160  = 2'd1,
    FREQ_400  = 2'd2,
    FREQ_1000 = 2'd3
  } clk_freq_e;

  // --------------------------------------------------------------------------
  // Life-cycle tokens driven while the token bundle is forced
  // --------------------------------------------------------------------------
  localparam logic [127:0] TEST_UNLOCK_TOKEN = 128'h3852305b_aecf5ff1_d5c1d25f_6db9058d;
  localparam logic [127:0] RMA_TOKEN         = 128'h67926115_6880f4cc_51785553_16c51e4d;

  // Multi-bit "on" encoding of the token valid fields
  localparam logic [3:0] TOKEN_VALID_ON = 4'b0101;

  // Zeroization values for the forced modes
  localparam logic [31:0] ROM_MASK_ON  = 32'hFFFF_FFFF;
  localparam logic [31:0] ROM_MASK_OFF = 32'h0000_0000;

  // Fuse DAI write-data register, target of the injected ECC fault
  localparam logic [31:0] FUSE_DAI_WDATA_ADDR = 32'h7000_0068;

endpackage

//--- svc_ovr_if.sv
// Override state interface
// Carries the sticky override state from the execute stage to the block
// that applies it to the subsystem signals

`timescale 1ns/1ps

interface svc_ovr_if
  import svc_ovr_pkg::*;
();

  awuser_mode_e  awuser_mode;
  zeroize_mode_e zeroize_mode;
  logic          token_force;
  logic          rma_scrap_ppd;
  logic          escalate;
  clk_freq_e     freq_sel;
  logic          digest_fault;
  logic          ecc_fault_en;

  modport exec (
    output awuser_mode,
    output zeroize_mode,
    output token_force,
    output rma_scrap_ppd,
    output escalate,
    output freq_sel,
    output digest_fault,
    output ecc_fault_en
  );

  modport result (
    input awuser_mode,
    input zeroize_mode,
    input token_force,
    input rma_scrap_ppd,
    input escalate,
    input freq_sel,
    input digest_fault,
    input ecc_fault_en
  );

endinterface

//--- svc_cmd_decode.sv
// Service command decoder
// Samples the host command strobe and byte, and presents the matching
// opcode to the execute stage one cycle later

`timescale 1ns/1ps

module svc_cmd_decode
  import svc_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       cptra_rst_b,
  input  logic       cmd_valid_i,
  input  logic [7:0] cmd_i,
  output logic       op_valid_o,
  output svc_op_e    op_o
);

  logic       op_valid_q;
  logic [7:0] cmd_q;

  // --------------------------------------------------------------------------
  // Input stage
  // --------------------------------------------------------------------------

  // The strobe is a single-cycle pulse and is never stretched
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      op_valid_q <= 1'b0;
    end else begin
      op_valid_q <= cmd_valid_i;
    end
  end

  // Command byte only matters together with the strobe
  always_ff @(posedge clk) begin
    if (cmd_valid_i) begin
      cmd_q <= cmd_i;
    end
  end

  // --------------------------------------------------------------------------
  // Decode
  // --------------------------------------------------------------------------

  // Unknown bytes still raise op_valid_o but carry OP_NONE
  always_comb begin
    op_o = cmd_to_op(cmd_q);
  end

  assign op_valid_o = op_valid_q;

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------

  // Every opcode comes from a strobe one cycle earlier
  a_op_valid_follows_cmd : assert property (
    @(posedge clk) disable iff (!cptra_rst_b)
    op_valid_o |-> $past(cmd_valid_i)
  );

endmodule

//--- svc_override_exec.sv
// Override execute stage
// Holds the sticky override state selected by the decoded opcodes and
// generates the fixed-length reset pulse for the fuse and life-cycle blocks

`timescale 1ns/1ps

module svc_override_exec
  import svc_cmd_pkg::*;
  import svc_ovr_pkg::*;
#(
  parameter int RESET_PULSE_LEN = 11
) (
  input  logic    clk,
  input  logic    cptra_rst_b,
  input  logic    op_valid_i,
  input  svc_op_e op_i,
  svc_ovr_if.exec ovr,
  output logic    sub_rst_b_o
);

  localparam int CNT_W = $clog2(RESET_PULSE_LEN + 1);

  awuser_mode_e     awuser_mode_q;
  zeroize_mode_e    zeroize_mode_q;
  clk_freq_e        freq_sel_q;
  logic             token_force_q;
  logic             rma_scrap_ppd_q;
  logic             escalate_q;
  logic             digest_fault_q;
  logic             ecc_fault_en_q;
  logic [CNT_W-1:0] rst_cnt_q;
  logic             pulse_active;
  logic             start_pulse;

  // --------------------------------------------------------------------------
  // Sticky override state
  // --------------------------------------------------------------------------

  // Modes can be switched back and forth, the flags only ever set
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      awuser_mode_q   <= AWU_PASS;
      zeroize_mode_q  <= ZER_PASS;
      freq_sel_q      <= FREQ_500;
      token_force_q   <= 1'b0;
      rma_scrap_ppd_q <= 1'b0;
      escalate_q      <= 1'b0;
      digest_fault_q  <= 1'b0;
      ecc_fault_en_q  <= 1'b0;
    end else if (op_valid_i) begin
      case (op_i)
        OP_AWUSER_CORE:     awuser_mode_q   <= AWU_CORE;
        OP_AWUSER_MCU:      awuser_mode_q   <= AWU_MCU;
        OP_AWUSER_RELEASE:  awuser_mode_q   <= AWU_PASS;
        OP_ZEROIZE_ON:      zeroize_mode_q  <= ZER_ON;
        OP_ZEROIZE_OFF:     zeroize_mode_q  <= ZER_OFF;
        OP_ZEROIZE_RELEASE: zeroize_mode_q  <= ZER_PASS;
        OP_FORCE_TOKENS:    token_force_q   <= 1'b1;
        OP_RMA_SCRAP_PPD:   rma_scrap_ppd_q <= 1'b1;
        OP_ESCALATE:        escalate_q      <= 1'b1;
        OP_CLK_500:         freq_sel_q      <= FREQ_500;
        OP_CLK_160:         freq_sel_q      <= FREQ_160;
        OP_CLK_400:         freq_sel_q      <= FREQ_400;
        OP_CLK_1000:        freq_sel_q      <= FREQ_1000;
        OP_FAULT_DIGEST:    digest_fault_q  <= 1'b1;
        OP_FAULT_BUS_ECC:   ecc_fault_en_q  <= 1'b1;
        // OP_SUB_RESET is handled by the pulse counter
        default: begin
        end
      endcase
    end
  end

  assign ovr.awuser_mode   = awuser_mode_q;
  assign ovr.zeroize_mode  = zeroize_mode_q;
  assign ovr.freq_sel      = freq_sel_q;
  assign ovr.token_force   = token_force_q;
  assign ovr.rma_scrap_ppd = rma_scrap_ppd_q;
  assign ovr.escalate      = escalate_q;
  assign ovr.digest_fault  = digest_fault_q;
  assign ovr.ecc_fault_en  = ecc_fault_en_q;

  // --------------------------------------------------------------------------
  // Subsystem reset pulse
  // --------------------------------------------------------------------------

  assign pulse_active = (rst_cnt_q != '0);

  // A new request is only accepted once the previous pulse has ended
  assign start_pulse = op_valid_i && (op_i == OP_SUB_RESET) && !pulse_active;

  // Counts the remaining low cycles down to zero
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      rst_cnt_q <= '0;
    end else if (start_pulse) begin
      rst_cnt_q <= CNT_W'(RESET_PULSE_LEN);
    end else if (pulse_active) begin
      rst_cnt_q <= rst_cnt_q - 1'b1;
    end
  end

  assign sub_rst_b_o = !pulse_active;

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------

  // The reset stays low for no more than the pulse length
  a_pulse_len_max : assert property (
    @(posedge clk) disable iff (!cptra_rst_b)
    !sub_rst_b_o [*RESET_PULSE_LEN] |=> sub_rst_b_o
  );

  // A second reset request inside the pulse does not reload the counter
  a_pulse_no_retrigger : assert property (
    @(posedge clk) disable iff (!cptra_rst_b)
    (op_valid_i && (op_i == OP_SUB_RESET) && pulse_active)
      |=> (rst_cnt_q == $past(rst_cnt_q) - 1'b1)
  );

endmodule

//--- svc_result.sv
// Override result stage
// Applies the override state to the subsystem signals, either passing the
// inputs through or driving the forced values, and injects the DAI fault

`timescale 1ns/1ps

module svc_result
  import svc_ovr_pkg::*;
#(
  parameter int AXI_USER_W = 32,
  parameter int DATA_W     = 32
) (
  svc_ovr_if.result        ovr,
  input  logic [AXI_USER_W-1:0] core_awuser_i,
  input  logic [AXI_USER_W-1:0] mcu_awuser_i,
  input  logic [AXI_USER_W-1:0] awuser_i,
  output logic [AXI_USER_W-1:0] awuser_o,
  input  logic                  zeroize_ppd_i,
  input  logic [31:0]           rom_mask_i,
  input  logic                  scrap_mode_i,
  output logic                  zeroize_ppd_o,
  output logic [31:0]           rom_mask_o,
  output logic                  scrap_mode_o,
  input  logic [127:0]          unlock_token_i,
  input  logic [127:0]          rma_token_i,
  input  logic [3:0]            tokens_valid_i,
  output logic [127:0]          unlock_token_o,
  output logic [127:0]          rma_token_o,
  output logic [3:0]            tokens_valid_o,
  input  logic                  rma_scrap_ppd_i,
  output logic                  rma_scrap_ppd_o,
  output logic                  escalate_o,
  output logic                  digest_fault_o,
  input  logic                  clk_byp_ack_i,
  output logic [1:0]            clk_freq_sel_o,
  input  logic                  dai_write_i,
  input  logic [DATA_W-1:0]     dai_addr_i,
  input  logic [DATA_W-1:0]     dai_wdata_i,
  output logic [DATA_W-1:0]     dai_wdata_o,
  input  logic [1:0]            bresp_i,
  output logic [1:0]            bresp_o
);

  logic ecc_hit;

  // Write user field
  always_comb begin
    case (ovr.awuser_mode)
      AWU_CORE: awuser_o = core_awuser_i;
      AWU_MCU:  awuser_o = mcu_awuser_i;
      default:  awuser_o = awuser_i;
    endcase
  end

  // Zeroization inputs, the ON and OFF modes drive opposite values
  always_comb begin
    zeroize_ppd_o = zeroize_ppd_i;
    rom_mask_o    = rom_mask_i;
    scrap_mode_o  = scrap_mode_i;
    if (ovr.zeroize_mode == ZER_ON) begin
      zeroize_ppd_o = 1'b1;
      rom_mask_o    = ROM_MASK_ON;
      scrap_mode_o  = 1'b0;
    end else if (ovr.zeroize_mode == ZER_OFF) begin
      zeroize_ppd_o = 1'b0;
      rom_mask_o    = ROM_MASK_OFF;
      scrap_mode_o  = 1'b1;
    end
  end

  assign unlock_token_o  = ovr.token_force ? TEST_UNLOCK_TOKEN : unlock_token_i;
  assign rma_token_o     = ovr.token_force ? RMA_TOKEN : rma_token_i;
  assign tokens_valid_o  = ovr.token_force ? TOKEN_VALID_ON : tokens_valid_i;
  assign rma_scrap_ppd_o = ovr.rma_scrap_ppd | rma_scrap_ppd_i;
  assign escalate_o      = ovr.escalate;
  assign digest_fault_o  = ovr.digest_fault;

  // Selected frequency only counts once the clock bypass is acknowledged
  assign clk_freq_sel_o = clk_byp_ack_i ? ovr.freq_sel : FREQ_500;

  // Single-bit fault on writes to the DAI write-data register
  assign ecc_hit = ovr.ecc_fault_en && dai_write_i &&
                   (dai_addr_i == DATA_W'(FUSE_DAI_WDATA_ADDR));
  assign dai_wdata_o = {dai_wdata_i[DATA_W-1:1], dai_wdata_i[0] ^ ecc_hit};

  // The error response from the faulted write is masked so traffic continues
  assign bresp_o = ovr.ecc_fault_en ? 2'b00 : bresp_i;

endmodule

//--- svc_top.sv
// Test-service override controller
// Decodes host service commands and drives the overridden fuse and
// life-cycle subsystem signals

`timescale 1ns/1ps

module svc_top
  import svc_cmd_pkg::*;
#(
  parameter int AXI_USER_W      = 32,
  parameter int DATA_W          = 32,
  parameter int RESET_PULSE_LEN = 11
) (
  input  logic                  clk,
  input  logic                  cptra_rst_b,
  input  logic                  cmd_valid_i,
  input  logic [7:0]            cmd_i,
  input  logic [AXI_USER_W-1:0] core_awuser_i,
  input  logic [AXI_USER_W-1:0] mcu_awuser_i,
  input  logic [AXI_USER_W-1:0] awuser_i,
  output logic [AXI_USER_W-1:0] awuser_o,
  input  logic                  zeroize_ppd_i,
  input  logic [31:0]           rom_mask_i,
  input  logic                  scrap_mode_i,
  output logic                  zeroize_ppd_o,
  output logic [31:0]           rom_mask_o,
  output logic                  scrap_mode_o,
  input  logic [127:0]          unlock_token_i,
  input  logic [127:0]          rma_token_i,
  input  logic [3:0]            tokens_valid_i,
  output logic [127:0]          unlock_token_o,
  output logic [127:0]          rma_token_o,
  output logic [3:0]            tokens_valid_o,
  input  logic                  rma_scrap_ppd_i,
  output logic                  rma_scrap_ppd_o,
  output logic                  escalate_o,
  output logic                  digest_fault_o,
  input  logic                  clk_byp_ack_i,
  output logic [1:0]            clk_freq_sel_o,
  input  logic                  dai_write_i,
  input  logic [DATA_W-1:0]     dai_addr_i,
  input  logic [DATA_W-1:0]     dai_wdata_i,
  output logic [DATA_W-1:0]     dai_wdata_o,
  input  logic [1:0]            bresp_i,
  output logic [1:0]            bresp_o,
  output logic                  sub_rst_b_o
);

  logic    op_valid;
  svc_op_e op;

  svc_ovr_if ovr_if ();

  svc_cmd_decode u_decode (
    .clk         (clk),
    .cptra_rst_b (cptra_rst_b),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .op_valid_o  (op_valid),
    .op_o        (op)
  );

  svc_override_exec #(
    .RESET_PULSE_LEN (RESET_PULSE_LEN)
  ) u_exec (
    .clk         (clk),
    .cptra_rst_b (cptra_rst_b),
    .op_valid_i  (op_valid),
    .op_i        (op),
    .ovr         (ovr_if.exec),
    .sub_rst_b_o (sub_rst_b_o)
  );

  svc_result #(
    .AXI_USER_W (AXI_USER_W),
    .DATA_W     (DATA_W)
  ) u_result (
    .ovr             (ovr_if.result),
    .core_awuser_i   (core_awuser_i),
    .mcu_awuser_i    (mcu_awuser_i),
    .awuser_i        (awuser_i),
    .awuser_o        (awuser_o),
    .zeroize_ppd_i   (zeroize_ppd_i),
    .rom_mask_i      (rom_mask_i),
    .scrap_mode_i    (scrap_mode_i),
    .zeroize_ppd_o   (zeroize_ppd_o),
    .rom_mask_o      (rom_mask_o),
    .scrap_mode_o    (scrap_mode_o),
    .unlock_token_i  (unlock_token_i),
    .rma_token_i     (rma_token_i),
    .tokens_valid_i  (tokens_valid_i),
    .unlock_token_o  (unlock_token_o),
    .rma_token_o     (rma_token_o),
    .tokens_valid_o  (tokens_valid_o),
    .rma_scrap_ppd_i (rma_scrap_ppd_i),
    .rma_scrap_ppd_o (rma_scrap_ppd_o),
    .escalate_o      (escalate_o),
    .digest_fault_o  (digest_fault_o),
    .clk_byp_ack_i   (clk_byp_ack_i),
    .clk_freq_sel_o  (clk_freq_sel_o),
    .dai_write_i     (dai_write_i),
    .dai_addr_i      (dai_addr_i),
    .dai_wdata_i     (dai_wdata_i),
    .dai_wdata_o     (dai_wdata_o),
    .bresp_i         (bresp_i),
    .bresp_o         (bresp_o)
  );

endmodule

//--- svc_top_tb.sv
// Testbench for the test-service override controller
// Applies the command vectors from svc_vectors.txt, fills the pass-through
// inputs from an LFSR and checks every override output

`timescale 1ns/1ps

module svc_top_tb
  import svc_cmd_pkg::*;
  import svc_ovr_pkg::*;
();

  localparam int AXI_USER_W = 32;
  localparam int DATA_W     = 32;
  localparam int PULSE_LEN  = 11;
  // Words per vector line and room for the whole file
  localparam int NF         = 16;
  localparam int MAX_WORDS  = 2048;

  logic                  clk;
  logic                  cptra_rst_b;
  logic                  cmd_valid_i;
  logic [7:0]            cmd_i;
  logic [AXI_USER_W-1:0] core_awuser_i, mcu_awuser_i, awuser_i, awuser_o;
  logic                  zeroize_ppd_i, scrap_mode_i, zeroize_ppd_o, scrap_mode_o;
  logic [31:0]           rom_mask_i, rom_mask_o;
  logic [127:0]          unlock_token_i, rma_token_i, unlock_token_o, rma_token_o;
  logic [3:0]            tokens_valid_i, tokens_valid_o;
  logic                  rma_scrap_ppd_i, rma_scrap_ppd_o;
  logic                  escalate_o, digest_fault_o;
  logic                  clk_byp_ack_i;
  logic [1:0]            clk_freq_sel_o;
  logic                  dai_write_i;
  logic [DATA_W-1:0]     dai_addr_i, dai_wdata_i, dai_wdata_o;
  logic [1:0]            bresp_i, bresp_o;
  logic                  sub_rst_b_o;

  logic [31:0] vec_mem [0:MAX_WORDS-1];
  logic [31:0] lfsr_state;
  int          nvec;
  int          err_cnt = 0;
  int          chk_cnt = 0;
  int          cycle_cnt = 0;
  int          timeout_limit = 0;
  int          neg_cnt = 0;
  int          strobe_neg = 0;
  int          low_cnt = 0;
  logic        srst_prev = 1'b1;

  svc_top #(
    .AXI_USER_W      (AXI_USER_W),
    .DATA_W          (DATA_W),
    .RESET_PULSE_LEN (PULSE_LEN)
  ) svc_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  // Galois LFSR, taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  task automatic take_bits(input int n, output logic [127:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    chk_cnt++;
    assert (got === exp) else begin
      err_cnt++;
      $display("Fail %s: got %0h, expected %0h", name, got, exp);
    end
  endtask

  // Drives one vector line at the next rising edge
  task automatic apply_vector(input int v);
    int           base;
    logic [127:0] r;
    base = v * NF;
    @(posedge clk);
    cmd_i         <= vec_mem[base][7:0];
    cmd_valid_i   <= vec_mem[base+1][0];
    dai_write_i   <= vec_mem[base+2][0];
    dai_addr_i    <= vec_mem[base+3];
    dai_wdata_i   <= vec_mem[base+4];
    clk_byp_ack_i <= vec_mem[base+5][0];
    take_bits(32, r);
    core_awuser_i <= r[31:0];
    take_bits(32, r);
    mcu_awuser_i <= r[31:0];
    take_bits(32, r);
    awuser_i <= r[31:0];
    take_bits(1, r);
    zeroize_ppd_i <= r[0];
    take_bits(32, r);
    rom_mask_i <= r[31:0];
    take_bits(1, r);
    scrap_mode_i <= r[0];
    take_bits(128, r);
    unlock_token_i <= r;
    take_bits(128, r);
    rma_token_i <= r;
    take_bits(4, r);
    tokens_valid_i <= r[3:0];
    take_bits(1, r);
    rma_scrap_ppd_i <= r[0];
    take_bits(2, r);
    bresp_i <= r[1:0];
  endtask

  // Expected outputs follow from the mode codes in the vector line
  task automatic check_vector(input int v);
    int          base;
    logic [31:0] exp_awuser;
    logic        exp_ppd;
    logic        exp_scrap;
    logic [31:0] exp_mask;
    logic        tok;
    base = v * NF;
    tok  = vec_mem[base+8][0];
    case (vec_mem[base+6])
      1:       exp_awuser = core_awuser_i;
      2:       exp_awuser = mcu_awuser_i;
      default: exp_awuser = awuser_i;
    endcase
    case (vec_mem[base+7])
      1: begin
        exp_ppd   = 1'b1;
        exp_mask  = 32'hFFFF_FFFF;
        exp_scrap = 1'b0;
      end
      2: begin
        exp_ppd   = 1'b0;
        exp_mask  = 32'h0;
        exp_scrap = 1'b1;
      end
      default: begin
        exp_ppd   = zeroize_ppd_i;
        exp_mask  = rom_mask_i;
        exp_scrap = scrap_mode_i;
      end
    endcase
    check_value("awuser_o", awuser_o, exp_awuser);
    check_value("zeroize_ppd_o", zeroize_ppd_o, exp_ppd);
    check_value("rom_mask_o", rom_mask_o, exp_mask);
    check_value("scrap_mode_o", scrap_mode_o, exp_scrap);
    check_value("unlock_token_o", unlock_token_o, tok ? TEST_UNLOCK_TOKEN : unlock_token_i);
    check_value("rma_token_o", rma_token_o, tok ? RMA_TOKEN : rma_token_i);
    check_value("tokens_valid_o", tokens_valid_o, tok ? 4'b0101 : tokens_valid_i);
    check_value("rma_scrap_ppd_o", rma_scrap_ppd_o, vec_mem[base+9][0] | rma_scrap_ppd_i);
    check_value("escalate_o", escalate_o, vec_mem[base+10][0]);
    check_value("digest_fault_o", digest_fault_o, vec_mem[base+11][0]);
    check_value("clk_freq_sel_o", clk_freq_sel_o, vec_mem[base+12][1:0]);
    check_value("dai_wdata_o", dai_wdata_o, vec_mem[base+13]);
    check_value("bresp_o", bresp_o, vec_mem[base+14][0] ? 2'b00 : bresp_i);
    check_value("sub_rst_b_o", sub_rst_b_o, vec_mem[base+15][0]);
  endtask

  // --------------------------------------------------------------------------
  // Reset pulse monitor
  // --------------------------------------------------------------------------

  // Measures start delay and width of every low pulse on sub_rst_b_o
  always @(negedge clk) begin
    if (cptra_rst_b) begin
      if (cmd_valid_i && cmd_i == CMD_SUB_RESET) begin
        strobe_neg = neg_cnt;
      end
      if (!sub_rst_b_o) begin
        if (srst_prev) begin
          check_value("sub_rst_b_o start delay", neg_cnt - strobe_neg, 2);
        end
        low_cnt++;
      end else begin
        if (low_cnt != 0) begin
          check_value("sub_rst_b_o pulse width", low_cnt, PULSE_LEN);
        end
        low_cnt = 0;
      end
      srst_prev = sub_rst_b_o;
    end
    neg_cnt++;
  end

  // --------------------------------------------------------------------------
  // Stimulus and timeout
  // --------------------------------------------------------------------------

  initial begin
    cptra_rst_b = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_i = '0;
    core_awuser_i = '0;
    mcu_awuser_i = '0;
    awuser_i = '0;
    zeroize_ppd_i = 1'b0;
    rom_mask_i = '0;
    scrap_mode_i = 1'b0;
    unlock_token_i = '0;
    rma_token_i = '0;
    tokens_valid_i = '0;
    rma_scrap_ppd_i = 1'b0;
    clk_byp_ack_i = 1'b0;
    dai_write_i = 1'b0;
    dai_addr_i = '0;
    dai_wdata_i = '0;
    bresp_i = '0;
    lfsr_state = 32'hc898;
    // Unread words keep a marker above the byte range of a command
    for (int i = 0; i < MAX_WORDS; i++) begin
      vec_mem[i] = 32'hFFFF_0000 | i;
    end
    $readmemh("svc_vectors.txt", vec_mem);
    nvec = 0;
    while ((nvec + 1) * NF <= MAX_WORDS && vec_mem[nvec * NF][31:8] == '0) begin
      nvec++;
    end
    if (nvec == 0) begin
      err_cnt++;
      $display("No vectors could be read from svc_vectors.txt");
    end
    timeout_limit = nvec * 4 + 40;
    repeat (5) @(posedge clk);
    cptra_rst_b <= 1'b1;
    for (int v = 0; v < nvec; v++) begin
      apply_vector(v);
      @(posedge clk);
      cmd_valid_i <= 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      check_vector(v);
    end
    repeat (2) @(posedge clk);
    $display("Errors: %0d in %0d checks over %0d vectors", err_cnt, chk_cnt, nvec);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    wait (timeout_limit > 0);
    while (cycle_cnt < timeout_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles with %0d errors, the vectors did not complete",
             cycle_cnt, err_cnt);
    $display("sim failed");
    $finish;
  end

endmodule

//--- svc_vectors.txt
// cmd valid write addr wdata ack, then expected: awu zer tok rma esc dig freq wdata bclr srst
// awu 0 pass 1 core 2 mcu, zer 0 pass 1 on 2 off, bclr 1 means bresp_o is 0, srst is sub_rst_b_o
00 0 0 00000000 00000000 0  0 0 0 0 0 0 0 00000000 0 1
00 0 1 70000068 12345678 1  0 0 0 0 0 0 0 12345678 0 1
01 1 0 00000000 00000000 0  1 0 0 0 0 0 0 00000000 0 1
02 1 0 00000000 00000000 0  2 0 0 0 0 0 0 00000000 0 1
03 1 0 00000000 00000000 0  0 0 0 0 0 0 0 00000000 0 1
04 1 0 00000000 00000000 0  0 1 0 0 0 0 0 00000000 0 1
05 1 0 00000000 00000000 0  0 2 0 0 0 0 0 00000000 0 1
06 1 0 00000000 00000000 0  0 0 0 0 0 0 0 00000000 0 1
07 1 0 00000000 00000000 0  0 0 1 0 0 0 0 00000000 0 1
08 1 0 00000000 00000000 0  0 0 1 1 0 0 0 00000000 0 1
09 1 0 00000000 00000000 0  0 0 1 1 1 0 0 00000000 0 1
0E 1 0 00000000 00000000 0  0 0 1 1 1 1 0 00000000 0 1
3C 1 0 00000000 00000000 0  0 0 1 1 1 1 0 00000000 0 1
0B 1 0 00000000 00000000 1  0 0 1 1 1 1 1 00000000 0 1
0C 1 0 00000000 00000000 1  0 0 1 1 1 1 2 00000000 0 1
0D 1 0 00000000 00000000 0  0 0 1 1 1 1 0 00000000 0 1
00 0 0 00000000 00000000 1  0 0 1 1 1 1 3 00000000 0 1
0A 1 0 00000000 00000000 1  0 0 1 1 1 1 0 00000000 0 1
0F 1 1 70000068 A5A5A5A4 0  0 0 1 1 1 1 0 A5A5A5A5 1 1
00 0 1 70000064 0000FFFF 0  0 0 1 1 1 1 0 0000FFFF 1 1
00 0 0 70000068 13579BDF 0  0 0 1 1 1 1 0 13579BDF 1 1
10 1 0 00000000 00000000 0  0 0 1 1 1 1 0 00000000 1 0
10 1 0 00000000 00000000 0  0 0 1 1 1 1 0 00000000 1 0
00 0 0 00000000 00000000 0  0 0 1 1 1 1 0 00000000 1 0
00 0 0 00000000 00000000 0  0 0 1 1 1 1 0 00000000 1 1

//--- vlog.f
svc_cmd_pkg.sv
svc_ovr_pkg.sv
svc_ovr_if.sv
svc_cmd_decode.sv
svc_override_exec.sv
svc_result.sv
svc_top.sv
svc_top_tb.sv

//--- Bender.yml
package:
  name: svc_override

sources:
  - svc_cmd_pkg.sv
  - svc_ovr_pkg.sv
  - svc_ovr_if.sv
  - svc_cmd_decode.sv
  - svc_override_exec.sv
  - svc_result.sv
  - svc_top.sv
  - target: test
    files:
      - svc_top_tb.sv
